//--- Makefile
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module convEngineTb -Mdir obj_dir -o convEngineTb
	./obj_dir/convEngineTb | tee $(LOG)
	@if grep -q "Regression failed" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "Regression passed" $(LOG) || (echo "Simulation ended without a verdict"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

//--- rtl/convEngine3x3.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_defs.svh"

module convEngine3x3 (
    input  logic             Clk,
    input  logic             Rst,
    input  logic             start,
    input  logic             keepWeights,
    input  convPkg::sample_t pushData,
    input  logic             pushValid,
    input  logic             resultReady,
    output logic             pushReady,
    output convPkg::sum_t    result,
    output logic             resultValid,
    output logic             busy
);
    import convPkg::*;

    sample_t                popData;
    logic                   popValid;
    logic                   pop;
    sample_t                laneA [`CONV_LANES];
    sample_t                laneB [`CONV_LANES];
    logic [`CONV_LANES-1:0] laneStart;
    logic                   clearAcc;
    sum_t                   laneSum [`CONV_LANES];
    logic                   lanesDone;
    logic                   resultTaken;
    logic                   abort;
    logic                   lanesClear;

    // Start low holds every stage clear
    assign abort      = ~start;
    assign lanesClear = abort | clearAcc;

    sampleFifo #(
        .DEPTH(`CONV_FIFO_DEPTH)
    ) i_sampleFifo (
        .Clk      (Clk),
        .Rst      (Rst),
        .flush    (abort),
        .pushData (pushData),
        .pushValid(pushValid),
        .pop      (pop),
        .pushReady(pushReady),
        .popData  (popData),
        .popValid (popValid)
    );

    operandLoader i_operandLoader (
        .Clk        (Clk),
        .Rst        (Rst),
        .start      (start),
        .keepWeights(keepWeights),
        .popData    (popData),
        .popValid   (popValid),
        .resultTaken(resultTaken),
        .pop        (pop),
        .laneA      (laneA),
        .laneB      (laneB),
        .laneStart  (laneStart),
        .clearAcc   (clearAcc),
        .busy       (busy)
    );

    macLanes i_macLanes (
        .Clk      (Clk),
        .Rst      (Rst),
        .clear    (lanesClear),
        .laneA    (laneA),
        .laneB    (laneB),
        .laneStart(laneStart),
        .laneSum  (laneSum),
        .lanesDone(lanesDone)
    );

    sumReducer i_sumReducer (
        .Clk        (Clk),
        .Rst        (Rst),
        .clear      (abort),
        .laneSum    (laneSum),
        .lanesDone  (lanesDone),
        .resultReady(resultReady),
        .result     (result),
        .resultValid(resultValid),
        .resultTaken(resultTaken)
    );

endmodule

`default_nettype wire

//--- rtl/convPkg.sv
`default_nettype none

`include "conv_defs.svh"

package convPkg;

    // One pixel or weight word as it sits in the FIFO
    typedef logic signed [`CONV_DATA_WIDTH-1:0] sample_t;

    // Lane accumulator and window result
    typedef logic signed [`CONV_SUM_WIDTH-1:0] sum_t;

    // Loader sequencing over one window
    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        LOAD  = 2'd1,
        FLUSH = 2'd2,
        DONE  = 2'd3
    } loaderState_e;

    // What the loader expects from the next popped word
    typedef enum logic {
        PIXEL  = 1'b0,
        WEIGHT = 1'b1
    } wordKind_e;

endpackage

`default_nettype wire

//--- rtl/conv_defs.svh
`ifndef CONV_DEFS_SVH
`define CONV_DEFS_SVH

// Width of one signed pixel or weight word
`define CONV_DATA_WIDTH 8

// Multiplier lanes working side by side
`define CONV_LANES 3

// Passes over the lanes per 3x3 window
`define CONV_LOOPS 3

// Entries in the sample FIFO, kept a power of two
`define CONV_FIFO_DEPTH 16

// Full product width plus four guard bits for the lane and window sums
`define CONV_SUM_WIDTH (2 * `CONV_DATA_WIDTH + 4)

`endif

//--- rtl/macLanes.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_defs.svh"

module macLanes (
    input  logic                   Clk,
    input  logic                   Rst,
    input  logic                   clear,
    input  convPkg::sample_t       laneA [`CONV_LANES],
    input  convPkg::sample_t       laneB [`CONV_LANES],
    input  logic [`CONV_LANES-1:0] laneStart,
    output convPkg::sum_t          laneSum [`CONV_LANES],
    output logic                   lanesDone
);
    import convPkg::*;

    localparam int TOTAL = `CONV_LANES * `CONV_LOOPS;
    localparam int CNT_W = $clog2(TOTAL + `CONV_LANES + 1);

    logic signed [2*`CONV_DATA_WIDTH-1:0] product [`CONV_LANES];
    logic [`CONV_LANES-1:0]               productValid;
    logic [CNT_W-1:0]                     accCnt;
    logic [CNT_W-1:0]                     nextCnt;

    // Product stage, one register per lane
    always_ff @(posedge Clk) begin
        for (int i = 0; i < `CONV_LANES; i++) begin
            if (laneStart[i]) begin
                product[i] <= laneA[i] * laneB[i];
            end
        end
    end

    always_ff @(posedge Clk or posedge Rst) begin
        if (Rst) begin
            productValid <= '0;
            for (int i = 0; i < `CONV_LANES; i++) begin
                laneSum[i] <= '0;
            end
        end else if (clear) begin
            productValid <= '0;
            for (int i = 0; i < `CONV_LANES; i++) begin
                laneSum[i] <= '0;
            end
        end else begin
            productValid <= laneStart;
            for (int i = 0; i < `CONV_LANES; i++) begin
                if (productValid[i]) begin
                    laneSum[i] <= laneSum[i] + sum_t'(product[i]);
                end
            end
        end
    end

    // Products accumulated this cycle, summed over all lanes
    always_comb begin
        nextCnt = accCnt;
        for (int i = 0; i < `CONV_LANES; i++) begin
            nextCnt = nextCnt + CNT_W'(productValid[i]);
        end
    end

    always_ff @(posedge Clk or posedge Rst) begin
        if (Rst) begin
            accCnt    <= '0;
            lanesDone <= 1'b0;
        end else if (clear) begin
            accCnt    <= '0;
            lanesDone <= 1'b0;
        end else begin
            lanesDone <= (nextCnt == CNT_W'(TOTAL));
            accCnt    <= (nextCnt == CNT_W'(TOTAL)) ? '0 : nextCnt;
        end
    end

endmodule

`default_nettype wire

//--- rtl/operandLoader.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_defs.svh"

module operandLoader (
    input  logic                   Clk,
    input  logic                   Rst,
    input  logic                   start,
    input  logic                   keepWeights,
    input  convPkg::sample_t       popData,
    input  logic                   popValid,
    input  logic                   resultTaken,
    output logic                   pop,
    output convPkg::sample_t       laneA [`CONV_LANES],
    output convPkg::sample_t       laneB [`CONV_LANES],
    output logic [`CONV_LANES-1:0] laneStart,
    output logic                   clearAcc,
    output logic                   busy
);
    import convPkg::*;

    localparam int PTR_W  = (`CONV_LANES > 1) ? $clog2(`CONV_LANES) : 1;
    localparam int LOOP_W = (`CONV_LOOPS > 1) ? $clog2(`CONV_LOOPS) : 1;
    localparam int TAPS   = `CONV_LANES * `CONV_LOOPS;
    localparam int TAP_W  = $clog2(TAPS);

    loaderState_e     state;
    wordKind_e        nextKind;
    logic [PTR_W-1:0] lanePtr;
    logic [LOOP_W-1:0] loopCnt;
    logic [TAP_W-1:0] tapIdx;
    logic             useHeld;
    logic             weightsValid;
    logic             pairDone;
    sample_t          weightStore [TAPS];

    assign pop    = (state == LOAD) && popValid;
    assign busy   = (state != IDLE);
    assign tapIdx = TAP_W'(loopCnt) * TAP_W'(`CONV_LANES) + TAP_W'(lanePtr);

    // A weight word closes the pair, or a lone pixel when weights are held
    assign pairDone = pop && ((nextKind == WEIGHT) || useHeld);

    always_ff @(posedge Clk or posedge Rst) begin
        if (Rst) begin
            state        <= IDLE;
            nextKind     <= PIXEL;
            lanePtr      <= '0;
            loopCnt      <= '0;
            useHeld      <= 1'b0;
            weightsValid <= 1'b0;
            laneStart    <= '0;
            clearAcc     <= 1'b0;
        end else if (!start) begin
            // Abort, stored weights are no longer trusted
            state        <= IDLE;
            nextKind     <= PIXEL;
            lanePtr      <= '0;
            loopCnt      <= '0;
            useHeld      <= 1'b0;
            weightsValid <= 1'b0;
            laneStart    <= '0;
            clearAcc     <= 1'b0;
        end else begin
            laneStart <= '0;
            clearAcc  <= 1'b0;
            case (state)
                IDLE: begin
                    // start is high here, so a window begins
                    clearAcc <= 1'b1;
                    useHeld  <= keepWeights && weightsValid;
                    nextKind <= PIXEL;
                    lanePtr  <= '0;
                    loopCnt  <= '0;
                    state    <= LOAD;
                end
                LOAD: begin
                    if (pop && !pairDone) begin
                        nextKind <= WEIGHT;
                    end
                    if (pairDone) begin
                        nextKind           <= PIXEL;
                        laneStart[lanePtr] <= 1'b1;
                        if (lanePtr == PTR_W'(`CONV_LANES - 1)) begin
                            lanePtr <= '0;
                            loopCnt <= loopCnt + 1'b1;
                            if (loopCnt == LOOP_W'(`CONV_LOOPS - 1)) begin
                                state <= FLUSH;
                            end
                        end else begin
                            lanePtr <= lanePtr + 1'b1;
                        end
                    end
                end
                // Last start pulse goes out during this cycle
                FLUSH: state <= DONE;
                DONE: begin
                    if (resultTaken) begin
                        weightsValid <= 1'b1;
                        state        <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Lane operands, weights come from the store in held mode
    always_ff @(posedge Clk or posedge Rst) begin
        if (Rst) begin
            for (int i = 0; i < `CONV_LANES; i++) begin
                laneA[i] <= '0;
                laneB[i] <= '0;
            end
        end else if (!start) begin
            for (int i = 0; i < `CONV_LANES; i++) begin
                laneA[i] <= '0;
                laneB[i] <= '0;
            end
        end else if (pop) begin
            if (nextKind == PIXEL) begin
                laneA[lanePtr] <= popData;
                if (useHeld) begin
                    laneB[lanePtr] <= weightStore[tapIdx];
                end
            end else begin
                laneB[lanePtr] <= popData;
            end
        end
    end

    // All nine weights of the last window, kept for reuse
    always_ff @(posedge Clk) begin
        if (pop && nextKind == WEIGHT) begin
            weightStore[tapIdx] <= popData;
        end
    end

    assert property (@(posedge Clk) disable iff (Rst) pop |-> popValid)
        else $error("operandLoader popped an empty FIFO");

endmodule

`default_nettype wire

//--- rtl/sampleFifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_defs.svh"

module sampleFifo #(
    parameter int DEPTH = `CONV_FIFO_DEPTH
) (
    input  logic                        Clk,
    input  logic                        Rst,
    input  logic                        flush,
    input  logic [`CONV_DATA_WIDTH-1:0] pushData,
    input  logic                        pushValid,
    input  logic                        pop,
    output logic                        pushReady,
    output logic [`CONV_DATA_WIDTH-1:0] popData,
    output logic                        popValid
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = PTR_W + 1;

    logic [`CONV_DATA_WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0]            wrPtr;
    logic [PTR_W-1:0]            rdPtr;
    logic [CNT_W-1:0]            count;
    logic                        readyEn;
    logic                        doPush;
    logic                        doPop;

    assign doPush    = pushValid && pushReady;
    assign doPop     = pop && popValid;
    // Ready stays low for the first cycle out of reset
    assign pushReady = readyEn && (count != CNT_W'(DEPTH));
    assign popValid  = (count != '0);
    assign popData   = mem[rdPtr];

    always_ff @(posedge Clk) begin
        if (doPush) begin
            mem[wrPtr] <= pushData;
        end
    end

    always_ff @(posedge Clk or posedge Rst) begin
        if (Rst) begin
            wrPtr   <= '0;
            rdPtr   <= '0;
            count   <= '0;
            readyEn <= 1'b0;
        end else begin
            readyEn <= 1'b1;
            if (flush) begin
                // Drop everything queued, takes effect at once
                wrPtr <= '0;
                rdPtr <= '0;
                count <= '0;
            end else begin
                if (doPush) begin
                    wrPtr <= (wrPtr == PTR_W'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;
                end
                if (doPop) begin
                    rdPtr <= (rdPtr == PTR_W'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
                end
                count <= count + CNT_W'(doPush) - CNT_W'(doPop);
            end
        end
    end

    // An underflow would wrap the count to a value above DEPTH
    assert property (@(posedge Clk) disable iff (Rst) count <= CNT_W'(DEPTH))
        else $error("sampleFifo occupancy out of range: %0d", count);

endmodule

`default_nettype wire

//--- rtl/sumReducer.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_defs.svh"

module sumReducer (
    input  logic          Clk,
    input  logic          Rst,
    input  logic          clear,
    input  convPkg::sum_t laneSum [`CONV_LANES],
    input  logic          lanesDone,
    input  logic          resultReady,
    output convPkg::sum_t result,
    output logic          resultValid,
    output logic          resultTaken
);
    import convPkg::*;

    sum_t total;
    logic handshake;

    assign handshake = resultValid && resultReady;

    always_comb begin
        total = '0;
        for (int i = 0; i < `CONV_LANES; i++) begin
            total = total + laneSum[i];
        end
    end

    // Window result, only loaded while no result is pending
    always_ff @(posedge Clk) begin
        if (lanesDone && !resultValid) begin
            result <= total;
        end
    end

    always_ff @(posedge Clk or posedge Rst) begin
        if (Rst) begin
            resultValid <= 1'b0;
            resultTaken <= 1'b0;
        end else if (clear) begin
            resultValid <= 1'b0;
            resultTaken <= 1'b0;
        end else begin
            resultTaken <= handshake;
            if (handshake) begin
                resultValid <= 1'b0;
            end else if (lanesDone) begin
                resultValid <= 1'b1;
            end
        end
    end

    // Held result must not move until the consumer takes it
    assert property (@(posedge Clk) disable iff (Rst || clear)
        resultValid && !resultReady |=> resultValid && $stable(result))
        else $error("sumReducer result changed under back-pressure");

endmodule

`default_nettype wire

//--- sim/convEngineTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_defs.svh"

module convEngineTb;

    localparam int DW      = `CONV_DATA_WIDTH;
    localparam int SW      = `CONV_SUM_WIDTH;
    localparam int TAPS    = `CONV_LANES * `CONV_LOOPS;
    localparam int DEPTH   = `CONV_FIFO_DEPTH;
    localparam int TIMEOUT = 2000;

    logic                 Clk;
    logic                 Rst;
    logic                 start;
    logic                 keepWeights;
    logic signed [DW-1:0] pushData;
    logic                 pushValid;
    logic                 resultReady;
    logic                 pushReady;
    logic signed [SW-1:0] result;
    logic                 resultValid;
    logic                 busy;

    // Current window operands in tap order
    logic signed [DW-1:0] px [TAPS];
    logic signed [DW-1:0] wt [TAPS];
    logic signed [SW-1:0] expQ [$];
    logic signed [SW-1:0] expected;
    int                   errorCount;
    int                   checkCount;
    int                   passCount;
    int                   failCount;

    convEngine3x3 i_convEngine3x3 (
        .Clk        (Clk),
        .Rst        (Rst),
        .start      (start),
        .keepWeights(keepWeights),
        .pushData   (pushData),
        .pushValid  (pushValid),
        .resultReady(resultReady),
        .pushReady  (pushReady),
        .result     (result),
        .resultValid(resultValid),
        .busy       (busy)
    );

    initial begin
        Clk = 1'b0;
        forever #5 Clk = ~Clk;
    end

    // Dot product of the nine pixels with the nine weights
    function automatic logic signed [SW-1:0] convRef(
        input logic signed [DW-1:0] pix [TAPS],
        input logic signed [DW-1:0] wgt [TAPS]
    );
        int acc;
        acc = 0;
        for (int i = 0; i < TAPS; i++) begin
            acc += int'(pix[i]) * int'(wgt[i]);
        end
        return acc[SW-1:0];
    endfunction

    // Every accepted result is compared against the oldest expected value
    always @(posedge Clk) begin
        if (!Rst && resultValid && resultReady) begin
            if (expQ.size() == 0) begin
                $display("Error at %0t: result %0d came out with no window pending",
                         $time, result);
                errorCount++;
            end else begin
                expected = expQ.pop_front();
                checkCount++;
                assert (result === expected) else begin
                    $display("Mismatch at %0t: window result expected %0d, got %0d",
                             $time, expected, result);
                    errorCount++;
                end
            end
        end
    end

    task automatic checkBit(input string what, input logic got, input logic want);
        checkCount++;
        assert (got === want) else begin
            $display("Mismatch at %0t: %s is %b, expected %b", $time, what, got, want);
            errorCount++;
        end
    endtask

    task automatic randWindow(input bit newWeights);
        for (int i = 0; i < TAPS; i++) begin
            px[i] = DW'($urandom);
            if (newWeights) begin
                wt[i] = DW'($urandom);
            end
        end
    endtask

    // Optional idle gap, then hold the word until the FIFO takes it
    task automatic pushWord(input logic signed [DW-1:0] word, input int maxGap);
        int waitCnt;
        waitCnt = 0;
        repeat ($urandom % (maxGap + 1)) begin
            @(posedge Clk);
            #1;
        end
        pushData  = word;
        pushValid = 1'b1;
        do begin
            @(posedge Clk);
            waitCnt++;
        end while (!pushReady && waitCnt < TIMEOUT);
        if (!pushReady) begin
            $display("Error at %0t: the FIFO never accepted a word", $time);
            errorCount++;
        end
        #1;
        pushValid = 1'b0;
    endtask

    task automatic pushWindow(input bit withWeights, input int maxGap);
        for (int i = 0; i < TAPS; i++) begin
            pushWord(px[i], maxGap);
            if (withWeights) begin
                pushWord(wt[i], maxGap);
            end
        end
    endtask

    task automatic waitValid();
        int waitCnt;
        waitCnt = 0;
        do begin
            @(posedge Clk);
            waitCnt++;
        end while (!resultValid && waitCnt < TIMEOUT);
        if (!resultValid) begin
            $display("Error at %0t: no result became valid", $time);
            errorCount++;
        end
        #1;
    endtask

    task automatic waitDrain();
        int waitCnt;
        waitCnt = 0;
        do begin
            @(posedge Clk);
            #1;
            waitCnt++;
        end while (expQ.size() != 0 && waitCnt < TIMEOUT);
        if (expQ.size() != 0) begin
            $display("Error at %0t: %0d expected results never arrived", $time, expQ.size());
            errorCount += expQ.size();
            expQ.delete();
        end
    endtask

    task automatic endTest(input string name, input int errorsBefore);
        if (errorCount == errorsBefore) begin
            passCount++;
            $display("Test %s: ok", name);
        end else begin
            failCount++;
            $display("Test %s: FAILED with %0d errors", name, errorCount - errorsBefore);
        end
    endtask

    initial begin
        int                   errorsBefore;
        int                   holdCycles;
        int                   accepted;
        bit                   full;
        logic signed [SW-1:0] held;
        logic signed [DW-1:0] words [$];
        void'($urandom(37041));
        Rst         = 1'b1;
        start       = 1'b0;
        keepWeights = 1'b0;
        pushData    = '0;
        pushValid   = 1'b0;
        resultReady = 1'b1;
        errorCount  = 0;
        checkCount  = 0;
        passCount   = 0;
        failCount   = 0;
        repeat (4) @(posedge Clk);
        #1;
        Rst = 1'b0;

        // Idle outputs, then one plain window
        errorsBefore = errorCount;
        @(posedge Clk);
        #1;
        checkBit("resultValid after reset", resultValid, 1'b0);
        checkBit("busy after reset", busy, 1'b0);
        checkBit("pushReady after reset", pushReady, 1'b1);
        start = 1'b1;
        randWindow(1'b1);
        expQ.push_back(convRef(px, wt));
        pushWindow(1'b1, 0);
        waitDrain();
        endTest("single window", errorsBefore);

        // Pixels only with the weights of the previous window
        errorsBefore = errorCount;
        keepWeights = 1'b1;
        randWindow(1'b0);
        expQ.push_back(convRef(px, wt));
        pushWindow(1'b0, 0);
        waitDrain();
        keepWeights = 1'b0;
        endTest("held weights", errorsBefore);

        errorsBefore = errorCount;
        resultReady = 1'b0;
        randWindow(1'b1);
        held = convRef(px, wt);
        expQ.push_back(held);
        pushWindow(1'b1, 0);
        waitValid();
        holdCycles = 5 + int'($urandom % 16);
        repeat (holdCycles) begin
            @(posedge Clk);
            checkBit("resultValid under back-pressure", resultValid, 1'b1);
            checkCount++;
            assert (result === held) else begin
                $display("Mismatch at %0t: held result expected %0d, got %0d",
                         $time, held, result);
                errorCount++;
            end
        end
        #1;
        resultReady = 1'b1;
        waitDrain();
        endTest("result back-pressure", errorsBefore);

        // Half a window, then abort
        errorsBefore = errorCount;
        randWindow(1'b1);
        for (int i = 0; i < 4; i++) begin
            pushWord(px[i], 0);
            pushWord(wt[i], 0);
        end
        start       = 1'b0;
        keepWeights = 1'b1;
        repeat (3) @(posedge Clk);
        #1;
        checkBit("resultValid after abort", resultValid, 1'b0);
        checkBit("busy after abort", busy, 1'b0);
        start = 1'b1;
        randWindow(1'b1);
        expQ.push_back(convRef(px, wt));
        pushWindow(1'b1, 0);
        waitDrain();
        keepWeights = 1'b0;
        endTest("abort and restart", errorsBefore);

        // Loader parked in DONE while the FIFO fills up
        errorsBefore = errorCount;
        resultReady = 1'b0;
        randWindow(1'b1);
        expQ.push_back(convRef(px, wt));
        pushWindow(1'b1, 0);
        waitValid();
        words.delete();
        repeat (2) begin
            randWindow(1'b1);
            expQ.push_back(convRef(px, wt));
            for (int i = 0; i < TAPS; i++) begin
                words.push_back(px[i]);
                words.push_back(wt[i]);
            end
        end
        accepted = 0;
        full     = 1'b0;
        while (!full && accepted < words.size()) begin
            pushData  = words[accepted];
            pushValid = 1'b1;
            @(posedge Clk);
            if (pushReady) begin
                accepted++;
            end else begin
                full = 1'b1;
            end
            #1;
        end
        pushValid = 1'b0;
        checkCount++;
        assert (accepted == DEPTH) else begin
            $display("Mismatch at %0t: FIFO took %0d words, expected %0d",
                     $time, accepted, DEPTH);
            errorCount++;
        end
        resultReady = 1'b1;
        for (int i = accepted; i < words.size(); i++) begin
            pushWord(words[i], 0);
        end
        waitDrain();
        endTest("full FIFO", errorsBefore);

        errorsBefore = errorCount;
        repeat (20) begin
            randWindow(1'b1);
            expQ.push_back(convRef(px, wt));
            pushWindow(1'b1, 3);
        end
        waitDrain();
        endTest("streamed windows", errorsBefore);

        $display("Tests passed: %0d, tests failed: %0d, results checked: %0d",
                 passCount, failCount, checkCount);
        if (errorCount == 0 && failCount == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+rtl
rtl/convPkg.sv
rtl/sampleFifo.sv
rtl/operandLoader.sv
rtl/macLanes.sv
rtl/sumReducer.sv
rtl/convEngine3x3.sv
sim/convEngineTb.sv
